// File: compile.f
+incdir+source
source/memStagePkg.sv
source/storeAligner.sv
source/cp0Regs.sv
source/memStage.sv
source/dataMemory.sv
source/memSubsystem.sv
bench/clockGen.sv
bench/memSubsystemTb.sv

// File: Makefile
TOP := memSubsystemTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// File: bench/memStim.txt
# in: name stall clr op pc alu rtData rtAddr rdAddr wrAddr wrData tnew wbAddr wbData
# out: op pc memCheck memWord offset wrAddr wrData tnew kernelCtrl epc (hex, after one edge)
alu1 0 0 1 100 1234 0 0 0 3 1234 2 0 0 1 100 0 0 0 3 1234 1 0 0
alu2 0 0 1 104 5679 0 0 0 4 deadbeef 0 0 0 1 104 0 0 1 4 deadbeef 0 0 0
alu3 0 0 1 108 5a6e 0 0 0 1f 600d 3 0 0 1 108 0 0 2 1f 600d 2 0 0
sw1 0 0 7 10c 40 11223344 8 0 0 0 0 0 0 7 10c 0 0 0 0 0 0 0 0
sh1 0 0 8 110 42 aabb 9 0 0 0 0 0 0 8 110 1 11223344 2 0 0 0 0 0
sb1 0 0 9 114 41 cc a 0 0 0 0 0 0 9 114 1 aabb3344 1 0 0 0 0 0
lw1 0 0 2 118 40 0 0 0 5 77 1 0 0 2 118 1 aabbcc44 0 5 aabbcc44 0 0 0
lbu1 0 0 6 11c 43 0 0 0 5 0 2 0 0 6 11c 1 aabbcc44 3 5 aabbcc44 1 0 0
swf 0 0 7 120 80 0 7 0 0 0 0 7 cafef00d 7 120 0 0 0 0 0 0 0 0
lwf 0 0 2 124 80 0 0 0 6 0 1 0 0 2 124 1 cafef00d 0 6 cafef00d 0 0 0
swz 0 0 7 128 84 13572468 0 0 0 0 0 0 ffffffff 7 128 0 0 0 0 0 0 0 0
lwz 0 0 2 12c 84 0 0 0 6 0 1 0 0 2 12c 1 13572468 0 6 13572468 0 0 0
mtsr 0 0 b 130 40 ff03 0 c 0 0 0 0 0 b 130 1 aabbcc44 0 0 0 0 3 0
mtepc 0 0 b 134 40 80000187 0 e 0 0 0 0 0 b 134 1 aabbcc44 0 0 0 0 3 20000061
mfepc 0 0 a 138 40 0 0 e 8 0 1 0 0 a 138 1 aabbcc44 0 8 80000184 0 3 20000061
mfsr 0 0 a 13c 40 0 0 c 8 0 0 0 0 a 13c 1 aabbcc44 0 8 3 0 3 20000061
mfprid 0 0 a 140 40 0 0 f 8 0 0 0 0 a 140 1 aabbcc44 0 8 4d45 0 3 20000061
eret 0 0 c 144 40 0 0 0 0 0 0 0 0 c 144 1 aabbcc44 0 0 0 0 1 20000061
mfsr2 0 0 a 148 40 0 0 c 8 0 0 0 0 a 148 1 aabbcc44 0 8 1 0 1 20000061
stallsw 1 0 7 14c 40 ffffffff 0 0 9 99 3 0 0 a 148 1 aabbcc44 0 8 1 0 1 20000061
lws 0 0 2 150 40 0 0 0 a 0 0 0 0 2 150 1 aabbcc44 0 a aabbcc44 0 1 20000061
clrsw 0 1 7 154 40 0 0 0 b 55 2 0 0 0 0 1 0 0 0 0 0 1 20000061
lwc 0 0 2 158 40 0 0 0 c 0 2 0 0 2 158 1 aabbcc44 0 c aabbcc44 1 1 20000061

// File: bench/memSubsystemTb.sv
// Memory subsystem testbench
// Replays stim vectors through the DUT and checks writeback and CP0 outputs
`timescale 1ns/1ns
`include "memStageSettings.svh"

module memSubsystemTb;

    localparam int RESET_CYCLES = 8;

    logic                    clk;
    logic                    rst;
    logic                    stall;
    logic                    clr;
    memStagePkg::memOp       instrMem;
    logic [`MS_DATA_W-1:0]   pcMem;
    logic [`MS_DATA_W-1:0]   aluOutMem;
    logic [`MS_DATA_W-1:0]   dataRtMem;
    logic [`MS_REG_W-1:0]    addrRtMem;
    logic [`MS_REG_W-1:0]    addrRdMem;
    logic [`MS_REG_W-1:0]    regWriteAddrMem;
    logic [`MS_DATA_W-1:0]   regWriteDataMem;
    logic [`MS_TNEW_W-1:0]   tnewMem;
    logic [`MS_REG_W-1:0]    regAddrWb;
    logic [`MS_DATA_W-1:0]   regDataWb;
    memStagePkg::memOp       instrWb;
    logic [`MS_DATA_W-1:0]   pcWb;
    logic [`MS_DATA_W-1:0]   memWordWb;
    logic [1:0]              offsetWb;
    logic [`MS_REG_W-1:0]    regWriteAddrWb;
    logic [`MS_DATA_W-1:0]   regWriteDataWb;
    logic [`MS_TNEW_W-1:0]   tnewWb;
    logic [1:0]              kernelCtrl;
    logic [`MS_DATA_W-3:0]   epc;

    // Vector text and the expected outputs of the vector in flight
    string       vectors[$];
    string       testName;
    logic [31:0] expInstr;
    logic [31:0] expPc;
    logic [31:0] memChk;
    logic [31:0] expMem;
    logic [31:0] expOff;
    logic [31:0] expWrAddr;
    logic [31:0] expWrData;
    logic [31:0] expTnew;
    logic [31:0] expKc;
    logic [31:0] expEpc;
    int          cycleCount;
    int          cycleLimit;
    int          failCount;

    clockGen #(.RESET_CYCLES(RESET_CYCLES)) clocks (
        .clk(clk),
        .rst(rst)
    );

    memSubsystem i_dut (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .clr            (clr),
        .instrMem       (instrMem),
        .pcMem          (pcMem),
        .aluOutMem      (aluOutMem),
        .dataRtMem      (dataRtMem),
        .addrRtMem      (addrRtMem),
        .addrRdMem      (addrRdMem),
        .regWriteAddrMem(regWriteAddrMem),
        .regWriteDataMem(regWriteDataMem),
        .tnewMem        (tnewMem),
        .regAddrWb      (regAddrWb),
        .regDataWb      (regDataWb),
        .instrWb        (instrWb),
        .pcWb           (pcWb),
        .memWordWb      (memWordWb),
        .offsetWb       (offsetWb),
        .regWriteAddrWb (regWriteAddrWb),
        .regWriteDataWb (regWriteDataWb),
        .tnewWb         (tnewWb),
        .kernelCtrl     (kernelCtrl),
        .epc            (epc)
    );

    task automatic checkValue(input string field, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            failCount++;
            $display("** Error %s %s: expected %h, actual %h", testName, field, expected, actual);
            $display("Verification failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic checkOutputs();
        checkValue("instrWb", expInstr, 32'(instrWb));
        checkValue("pcWb", expPc, pcWb);
        // First access to a word has no defined old contents
        if (memChk[0]) begin
            checkValue("memWordWb", expMem, memWordWb);
        end
        checkValue("offsetWb", expOff, 32'(offsetWb));
        checkValue("regWriteAddrWb", expWrAddr, 32'(regWriteAddrWb));
        checkValue("regWriteDataWb", expWrData, regWriteDataWb);
        checkValue("tnewWb", expTnew, 32'(tnewWb));
        checkValue("kernelCtrl", expKc, 32'(kernelCtrl));
        checkValue("epc", expEpc, 32'(epc));
    endtask

    task automatic loadVectors();
        int    fd;
        string line;
        fd = $fopen("bench/memStim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stim file bench/memStim.txt");
            $display("Verification failed");
            $fatal(1, "missing stim file");
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) != 0) begin
                // Skip column notes and blank lines
                if (line.len() > 1 && line.getc(0) != "#") begin
                    vectors.push_back(line);
                end
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("The stim file holds no vectors");
            $display("Verification failed");
            $fatal(1, "empty stim file");
        end
    endtask

    task automatic applyVector(input string text);
        logic [3:0] opCode;
        int         count;
        count = $sscanf(text,
            "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            testName, stall, clr, opCode, pcMem, aluOutMem, dataRtMem, addrRtMem,
            addrRdMem, regWriteAddrMem, regWriteDataMem, tnewMem, regAddrWb, regDataWb,
            expInstr, expPc, memChk, expMem, expOff, expWrAddr, expWrData, expTnew,
            expKc, expEpc);
        if (count != 24) begin
            $display("Malformed stim line: %s", text);
            $display("Verification failed");
            $fatal(1, "bad stim line");
        end
        instrMem = memStagePkg::memOp'(opCode);
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles with vectors still pending", cycleLimit);
            $display("Verification failed");
            $fatal(1, "cycle limit reached");
        end
    end

    initial begin
        int idx;
        stall           = 1'b0;
        clr             = 1'b0;
        instrMem        = memStagePkg::opNop;
        pcMem           = '0;
        aluOutMem       = '0;
        dataRtMem       = '0;
        addrRtMem       = '0;
        addrRdMem       = '0;
        regWriteAddrMem = '0;
        regWriteDataMem = '0;
        tnewMem         = '0;
        regAddrWb       = '0;
        regDataWb       = '0;
        failCount       = 0;
        cycleCount      = 0;
        cycleLimit      = 1000;

        loadVectors();
        cycleLimit = vectors.size() + RESET_CYCLES + 20;

        do begin
            @(negedge clk);
        end while (rst !== 1'b0);

        // Everything starts from zero after reset
        testName  = "reset";
        expInstr  = '0;
        expPc     = '0;
        memChk    = 32'd1;
        expMem    = '0;
        expOff    = '0;
        expWrAddr = '0;
        expWrData = '0;
        expTnew   = '0;
        expKc     = '0;
        expEpc    = '0;
        checkOutputs();

        for (idx = 0; idx < vectors.size(); idx++) begin
            applyVector(vectors[idx]);
            @(negedge clk);
            checkOutputs();
        end

        if (failCount == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            $display("Verification failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: bench/clockGen.sv
// Testbench clock and reset
// 10 ns clock with reset held for a fixed number of cycles
`timescale 1ns/1ns

module clockGen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Released after the last reset edge has been sampled
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: source/memSubsystem.sv
// Memory subsystem top
// Memory stage wired to its data memory
`timescale 1ns/1ns
`include "memStageSettings.svh"

module memSubsystem (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     clr,
    input  memStagePkg::memOp        instrMem,
    input  logic [`MS_DATA_W-1:0]    pcMem,
    input  logic [`MS_DATA_W-1:0]    aluOutMem,
    input  logic [`MS_DATA_W-1:0]    dataRtMem,
    input  logic [`MS_REG_W-1:0]     addrRtMem,
    input  logic [`MS_REG_W-1:0]     addrRdMem,
    input  logic [`MS_REG_W-1:0]     regWriteAddrMem,
    input  logic [`MS_DATA_W-1:0]    regWriteDataMem,
    input  logic [`MS_TNEW_W-1:0]    tnewMem,
    input  logic [`MS_REG_W-1:0]     regAddrWb,
    input  logic [`MS_DATA_W-1:0]    regDataWb,
    output memStagePkg::memOp        instrWb,
    output logic [`MS_DATA_W-1:0]    pcWb,
    output logic [`MS_DATA_W-1:0]    memWordWb,
    output logic [1:0]               offsetWb,
    output logic [`MS_REG_W-1:0]     regWriteAddrWb,
    output logic [`MS_DATA_W-1:0]    regWriteDataWb,
    output logic [`MS_TNEW_W-1:0]    tnewWb,
    output logic [1:0]               kernelCtrl,
    output logic [`MS_DATA_W-3:0]    epc
);

    // Data memory port
    logic [`MS_DATA_W-3:0]   dmAddr;
    logic [`MS_DATA_W-1:0]   dmWData;
    logic [3:0]              dmWe;
    logic [`MS_DATA_W-1:0]   dmRData;

    memStage stage (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .clr            (clr),
        .instrMem       (instrMem),
        .pcMem          (pcMem),
        .aluOutMem      (aluOutMem),
        .dataRtMem      (dataRtMem),
        .addrRtMem      (addrRtMem),
        .addrRdMem      (addrRdMem),
        .regWriteAddrMem(regWriteAddrMem),
        .regWriteDataMem(regWriteDataMem),
        .tnewMem        (tnewMem),
        .regAddrWb      (regAddrWb),
        .regDataWb      (regDataWb),
        .dmRData        (dmRData),
        .dmAddr         (dmAddr),
        .dmWData        (dmWData),
        .dmWe           (dmWe),
        .instrWb        (instrWb),
        .pcWb           (pcWb),
        .memWordWb      (memWordWb),
        .offsetWb       (offsetWb),
        .regWriteAddrWb (regWriteAddrWb),
        .regWriteDataWb (regWriteDataWb),
        .tnewWb         (tnewWb),
        .kernelCtrl     (kernelCtrl),
        .epc            (epc)
    );

    dataMemory dmem (
        .clk  (clk),
        .rst  (rst),
        .addr (dmAddr),
        .wData(dmWData),
        .we   (dmWe),
        .rData(dmRData)
    );

endmodule

// File: source/dataMemory.sv
// Data memory
// Word RAM with byte-lane writes and combinational read
`timescale 1ns/1ns
`include "memStageSettings.svh"

module dataMemory (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`MS_DATA_W-3:0]    addr,
    input  logic [`MS_DATA_W-1:0]    wData,
    input  logic [3:0]               we,
    output logic [`MS_DATA_W-1:0]    rData
);

    localparam int IDX_W = $clog2(`MS_MEM_WORDS);

    logic [`MS_DATA_W-1:0] mem [0:`MS_MEM_WORDS-1];
    logic [IDX_W-1:0]      idx;

    assign idx = addr[IDX_W-1:0];

    always_ff @(posedge clk) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (we[lane]) begin
                mem[idx][lane*8 +: 8] <= wData[lane*8 +: 8];
            end
        end
    end

    assign rData = mem[idx];

    // Upper bits are dropped by the index, so such a write would alias
    assert property (@(posedge clk) disable iff (rst)
        we != 4'b0000 |-> addr < `MS_MEM_WORDS)
        else $error("data memory write beyond depth, word %h", addr);

endmodule

// File: source/memStage.sv
// Memory pipeline stage
// Store forwarding, CP0 access, writeback select and the MEM/WB register
`timescale 1ns/1ns
`include "memStageSettings.svh"

module memStage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     stall,
    input  logic                     clr,
    input  memStagePkg::memOp        instrMem,
    input  logic [`MS_DATA_W-1:0]    pcMem,
    input  logic [`MS_DATA_W-1:0]    aluOutMem,
    input  logic [`MS_DATA_W-1:0]    dataRtMem,
    input  logic [`MS_REG_W-1:0]     addrRtMem,
    input  logic [`MS_REG_W-1:0]     addrRdMem,
    input  logic [`MS_REG_W-1:0]     regWriteAddrMem,
    input  logic [`MS_DATA_W-1:0]    regWriteDataMem,
    input  logic [`MS_TNEW_W-1:0]    tnewMem,
    input  logic [`MS_REG_W-1:0]     regAddrWb,
    input  logic [`MS_DATA_W-1:0]    regDataWb,
    input  logic [`MS_DATA_W-1:0]    dmRData,
    output logic [`MS_DATA_W-3:0]    dmAddr,
    output logic [`MS_DATA_W-1:0]    dmWData,
    output logic [3:0]               dmWe,
    output memStagePkg::memOp        instrWb,
    output logic [`MS_DATA_W-1:0]    pcWb,
    output logic [`MS_DATA_W-1:0]    memWordWb,
    output logic [1:0]               offsetWb,
    output logic [`MS_REG_W-1:0]     regWriteAddrWb,
    output logic [`MS_DATA_W-1:0]    regWriteDataWb,
    output logic [`MS_TNEW_W-1:0]    tnewWb,
    output logic [1:0]               kernelCtrl,
    output logic [`MS_DATA_W-3:0]    epc
);

    logic [`MS_DATA_W-1:0]   rtFwd;
    logic [3:0]              byteWe;
    logic [1:0]              offset;
    logic [`MS_DATA_W-1:0]   cp0Data;
    logic                    stageWriteEn;
    logic                    isLoad;
    logic [`MS_DATA_W-1:0]   wbData;
    logic [`MS_TNEW_W-1:0]   tnewNext;

    // WB-to-MEM bypass except for register zero
    assign rtFwd = (regAddrWb == addrRtMem && regAddrWb != '0) ? regDataWb : dataRtMem;

    // No side effects from a held or flushed op
    assign stageWriteEn = !stall && !clr;

    storeAligner aligner (
        .instr      (instrMem),
        .addr       (aluOutMem),
        .wData      (rtFwd),
        .wordAddr   (dmAddr),
        .byteWe     (byteWe),
        .alignedData(dmWData),
        .offset     (offset)
    );

    assign dmWe = stageWriteEn ? byteWe : 4'b0000;

    cp0Regs cp0 (
        .clk       (clk),
        .rst       (rst),
        .writeEn   (stageWriteEn),
        .instr     (instrMem),
        .regNum    (addrRdMem),
        .wData     (rtFwd),
        .pc        (pcMem),
        .rData     (cp0Data),
        .kernelCtrl(kernelCtrl),
        .epc       (epc)
    );

    assign isLoad = instrMem inside {memStagePkg::opLw, memStagePkg::opLh, memStagePkg::opLhu,
                                     memStagePkg::opLb, memStagePkg::opLbu};

    always_comb begin
        if (isLoad) begin
            wbData = dmRData;
        end else if (instrMem == memStagePkg::opMfc0) begin
            wbData = cp0Data;
        end else begin
            wbData = regWriteDataMem;
        end
    end

    // Saturating countdown
    assign tnewNext = (tnewMem != '0) ? tnewMem - 1'b1 : '0;

    always_ff @(posedge clk) begin
        if (rst || clr) begin
            instrWb        <= memStagePkg::opNop;
            pcWb           <= '0;
            memWordWb      <= '0;
            offsetWb       <= '0;
            regWriteAddrWb <= '0;
            regWriteDataWb <= '0;
            tnewWb         <= '0;
        end else if (!stall) begin
            instrWb        <= instrMem;
            pcWb           <= pcMem;
            // Raw word and offset for extension in writeback
            memWordWb      <= dmRData;
            offsetWb       <= offset;
            regWriteAddrWb <= regWriteAddrMem;
            regWriteDataWb <= wbData;
            tnewWb         <= tnewNext;
        end
    end

endmodule

// File: source/cp0Regs.sv
// Coprocessor 0 registers
// Status, cause, EPC and PRId with mtc0 writes, mfc0 reads and eret
`timescale 1ns/1ns
`include "memStageSettings.svh"

module cp0Regs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     writeEn,
    input  memStagePkg::memOp        instr,
    input  logic [`MS_REG_W-1:0]     regNum,
    input  logic [`MS_DATA_W-1:0]    wData,
    input  logic [`MS_DATA_W-1:0]    pc,
    output logic [`MS_DATA_W-1:0]    rData,
    output logic [1:0]               kernelCtrl,
    output logic [`MS_DATA_W-3:0]    epc
);

    // Fixed processor id
    localparam logic [`MS_DATA_W-1:0] PRID_VALUE = 32'h0000_4d45;

    logic                    srIe;
    logic                    srExl;
    logic [`MS_DATA_W-3:0]   epcReg;
    memStagePkg::cp0Sel      sel;
    logic                    mapped;

    // Register number to select
    always_comb begin
        sel    = memStagePkg::selSr;
        mapped = 1'b1;
        case (regNum)
            `MS_REG_W'(`MS_CP0_SR):    sel = memStagePkg::selSr;
            `MS_REG_W'(`MS_CP0_CAUSE): sel = memStagePkg::selCause;
            `MS_REG_W'(`MS_CP0_EPC):   sel = memStagePkg::selEpc;
            `MS_REG_W'(`MS_CP0_PRID):  sel = memStagePkg::selPrid;
            default:                   mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            srIe   <= 1'b0;
            srExl  <= 1'b0;
            epcReg <= '0;
        end else if (writeEn) begin
            if (instr == memStagePkg::opMtc0 && mapped) begin
                // Cause and PRId ignore writes
                case (sel)
                    memStagePkg::selSr: begin
                        srIe  <= wData[0];
                        srExl <= wData[1];
                    end
                    memStagePkg::selEpc: begin
                        epcReg <= wData[`MS_DATA_W-1:2];
                    end
                    default: begin
                    end
                endcase
            end
            if (instr == memStagePkg::opEret) begin
                srExl <= 1'b0;
            end
        end
    end

    always_comb begin
        rData = '0;
        if (mapped) begin
            case (sel)
                memStagePkg::selSr:    rData = {30'd0, srExl, srIe};
                memStagePkg::selCause: rData = '0;
                memStagePkg::selEpc:   rData = {epcReg, 2'b00};
                memStagePkg::selPrid:  rData = PRID_VALUE;
                default:               rData = '0;
            endcase
        end
    end

    assign kernelCtrl = {srExl, srIe};
    assign epc        = epcReg;

    // Kernel control must come out of reset with interrupts off
    assert property (@(posedge clk) rst |=> kernelCtrl == 2'b00)
        else $error("kernelCtrl not cleared by reset");

    // CP0 ops arrive from a word-aligned fetch
    assert property (@(posedge clk) disable iff (rst)
        writeEn && (instr == memStagePkg::opMtc0 || instr == memStagePkg::opEret)
            |-> pc[1:0] == 2'b00)
        else $error("CP0 op with unaligned pc %h", pc);

endmodule

// File: source/storeAligner.sv
// Store aligner
// Builds word address, byte enables and lane-replicated data for stores
`timescale 1ns/1ns
`include "memStageSettings.svh"

module storeAligner (
    input  memStagePkg::memOp        instr,
    input  logic [`MS_DATA_W-1:0]    addr,
    input  logic [`MS_DATA_W-1:0]    wData,
    output logic [`MS_DATA_W-3:0]    wordAddr,
    output logic [3:0]               byteWe,
    output logic [`MS_DATA_W-1:0]    alignedData,
    output logic [1:0]               offset
);

    assign wordAddr = addr[`MS_DATA_W-1:2];
    assign offset   = addr[1:0];

    always_comb begin
        byteWe      = 4'b0000;
        alignedData = wData;
        case (instr)
            memStagePkg::opSw: begin
                byteWe = 4'b1111;
            end
            memStagePkg::opSh: begin
                // Upper or lower half picked by addr bit 1
                byteWe      = addr[1] ? 4'b1100 : 4'b0011;
                alignedData = {2{wData[15:0]}};
            end
            memStagePkg::opSb: begin
                byteWe      = 4'b0001 << offset;
                alignedData = {4{wData[7:0]}};
            end
            default: begin
                byteWe = 4'b0000;
            end
        endcase
    end

    // Address generation upstream must keep stores naturally aligned
    always_comb begin
        assert final (!(instr == memStagePkg::opSw && offset != 2'b00))
            else $error("sw with unaligned address %h", addr);
        assert final (!(instr == memStagePkg::opSh && offset[0]))
            else $error("sh with odd address %h", addr);
    end

endmodule

// File: source/memStagePkg.sv
// Memory stage types
// Decoded operation codes and the CP0 register select
package memStagePkg;

    // Operation class handed over from execute
    typedef enum logic [3:0] {
        opNop,
        opAlu,
        opLw,
        opLh,
        opLhu,
        opLb,
        opLbu,
        opSw,
        opSh,
        opSb,
        opMfc0,
        opMtc0,
        opEret
    } memOp;

    // Mapped CP0 registers
    typedef enum logic [1:0] {
        selSr,
        selCause,
        selEpc,
        selPrid
    } cp0Sel;

endpackage

// File: source/memStageSettings.svh
// Memory stage settings
// Widths, memory depth and CP0 register numbers shared by the RTL
`ifndef MEM_STAGE_SETTINGS_SVH
`define MEM_STAGE_SETTINGS_SVH

// Data path and address width
`define MS_DATA_W 32

// GPR address width
`define MS_REG_W 5

// Tnew counter width
`define MS_TNEW_W 2

// Data memory depth in 32-bit words
`define MS_MEM_WORDS 256

// CP0 register numbers
`define MS_CP0_SR 12
`define MS_CP0_CAUSE 13
`define MS_CP0_EPC 14
`define MS_CP0_PRID 15

`endif
